// ==== rtl/rvdec_pkg.sv ====
`default_nettype none

package rvdec_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  localparam int XLEN       = 64;  // Integer data width
  localparam int ILEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;  // Integer register file only

  //////////////////////////////
  // Opcodes
  //////////////////////////////

  // Zero value doubles as the reset state of the output register
  typedef enum logic [7:0] {
    FN_INVALID,
    // Upper immediates and jumps
    FN_LUI, FN_AUIPC, FN_JAL, FN_JALR,
    // Branches
    FN_BEQ, FN_BNE, FN_BLT, FN_BGE, FN_BLTU, FN_BGEU,
    // Loads
    FN_LB, FN_LH, FN_LW, FN_LD, FN_LBU, FN_LHU, FN_LWU,
    // Stores
    FN_SB, FN_SH, FN_SW, FN_SD,
    // ALU immediate
    FN_ADDI, FN_SLTI, FN_SLTIU, FN_XORI, FN_ORI, FN_ANDI,
    FN_SLLI, FN_SRLI, FN_SRAI,
    // ALU register
    FN_ADD, FN_SUB, FN_SLL, FN_SLT, FN_SLTU,
    FN_XOR, FN_SRL, FN_SRA, FN_OR, FN_AND,
    // 32-bit word ops
    FN_ADDIW, FN_SLLIW, FN_SRLIW, FN_SRAIW,
    FN_ADDW, FN_SUBW, FN_SLLW, FN_SRLW, FN_SRAW,
    // M extension
    FN_MUL, FN_MULH, FN_MULHSU, FN_MULHU,
    FN_DIV, FN_DIVU, FN_REM, FN_REMU,
    FN_MULW, FN_DIVW, FN_DIVUW, FN_REMW, FN_REMUW,
    // CSR access
    FN_CSRRW, FN_CSRRS, FN_CSRRC,
    FN_CSRRWI, FN_CSRRSI, FN_CSRRCI,
    // System
    FN_FENCE, FN_ECALL, FN_EBREAK, FN_MRET, FN_WFI
  } instr_func_e;

  typedef enum logic [2:0] {
    IMM_NONE,
    IMM_SHAMT,  // Shift amount, bits 25:20
    IMM_B,
    IMM_CSR,    // CSR address plus uimm
    IMM_I,
    IMM_J,
    IMM_S,
    IMM_U
  } imm_fmt_e;

  //////////////////////////////
  // Decoded records
  //////////////////////////////

  typedef struct packed {
    logic use_rd;
    logic use_rs1;
    logic use_rs2;
  } reg_use_t;

  typedef struct packed {
    instr_func_e func;
    imm_fmt_e    imm_fmt;
    reg_use_t    reg_use;
    logic        mem_op;    // Load or store
    logic        blocking;  // Stalls younger instructions
  } instr_ctrl_t;

  typedef struct packed {
    instr_func_e           func;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       pc;
    logic                  mem_op;
    logic                  blocking;
    logic [NUM_REGS-1:0]   reg_req;  // One bit per register touched
  } decoded_instr_t;

endpackage

`default_nettype wire

// ==== rtl/instr_matcher.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_matcher (
  input  logic [rvdec_pkg::ILEN-1:0] code_i,
  output rvdec_pkg::instr_ctrl_t     ctrl_o
);

  import rvdec_pkg::*;

  instr_func_e func;

  logic is_valid;
  logic is_branch;
  logic is_load;
  logic is_store;
  logic is_upper;     // LUI, AUIPC
  logic is_shift_imm;
  logic is_alu_imm;
  logic is_alu_reg;   // Includes M extension
  logic is_csr_reg;
  logic is_csr_imm;
  logic is_sys;       // ECALL, EBREAK, MRET, WFI

  function automatic logic match_at(
    input logic [ILEN-1:0] code,
    input logic [ILEN-1:0] mask,
    input logic [ILEN-1:0] pattern
  );
    return (code & mask) == pattern;
  endfunction

  //////////////////////////////
  // Mask and match table
  //////////////////////////////

  always_comb begin
    func = FN_INVALID;
    if      (match_at(code_i, 32'h0000007F, 32'h00000037)) func = FN_LUI;
    else if (match_at(code_i, 32'h0000007F, 32'h00000017)) func = FN_AUIPC;
    else if (match_at(code_i, 32'h0000007F, 32'h0000006F)) func = FN_JAL;
    else if (match_at(code_i, 32'h0000707F, 32'h00000067)) func = FN_JALR;
    else if (match_at(code_i, 32'h0000707F, 32'h00000063)) func = FN_BEQ;
    else if (match_at(code_i, 32'h0000707F, 32'h00001063)) func = FN_BNE;
    else if (match_at(code_i, 32'h0000707F, 32'h00004063)) func = FN_BLT;
    else if (match_at(code_i, 32'h0000707F, 32'h00005063)) func = FN_BGE;
    else if (match_at(code_i, 32'h0000707F, 32'h00006063)) func = FN_BLTU;
    else if (match_at(code_i, 32'h0000707F, 32'h00007063)) func = FN_BGEU;
    else if (match_at(code_i, 32'h0000707F, 32'h00000003)) func = FN_LB;
    else if (match_at(code_i, 32'h0000707F, 32'h00001003)) func = FN_LH;
    else if (match_at(code_i, 32'h0000707F, 32'h00002003)) func = FN_LW;
    else if (match_at(code_i, 32'h0000707F, 32'h00003003)) func = FN_LD;
    else if (match_at(code_i, 32'h0000707F, 32'h00004003)) func = FN_LBU;
    else if (match_at(code_i, 32'h0000707F, 32'h00005003)) func = FN_LHU;
    else if (match_at(code_i, 32'h0000707F, 32'h00006003)) func = FN_LWU;
    else if (match_at(code_i, 32'h0000707F, 32'h00000023)) func = FN_SB;
    else if (match_at(code_i, 32'h0000707F, 32'h00001023)) func = FN_SH;
    else if (match_at(code_i, 32'h0000707F, 32'h00002023)) func = FN_SW;
    else if (match_at(code_i, 32'h0000707F, 32'h00003023)) func = FN_SD;
    else if (match_at(code_i, 32'h0000707F, 32'h00000013)) func = FN_ADDI;
    else if (match_at(code_i, 32'h0000707F, 32'h00002013)) func = FN_SLTI;
    else if (match_at(code_i, 32'h0000707F, 32'h00003013)) func = FN_SLTIU;
    else if (match_at(code_i, 32'h0000707F, 32'h00004013)) func = FN_XORI;
    else if (match_at(code_i, 32'h0000707F, 32'h00006013)) func = FN_ORI;
    else if (match_at(code_i, 32'h0000707F, 32'h00007013)) func = FN_ANDI;
    // RV64 shifts carry a 6-bit shamt
    else if (match_at(code_i, 32'hFC00707F, 32'h00001013)) func = FN_SLLI;
    else if (match_at(code_i, 32'hFC00707F, 32'h00005013)) func = FN_SRLI;
    else if (match_at(code_i, 32'hFC00707F, 32'h40005013)) func = FN_SRAI;
    else if (match_at(code_i, 32'hFE00707F, 32'h00000033)) func = FN_ADD;
    else if (match_at(code_i, 32'hFE00707F, 32'h40000033)) func = FN_SUB;
    else if (match_at(code_i, 32'hFE00707F, 32'h00001033)) func = FN_SLL;
    else if (match_at(code_i, 32'hFE00707F, 32'h00002033)) func = FN_SLT;
    else if (match_at(code_i, 32'hFE00707F, 32'h00003033)) func = FN_SLTU;
    else if (match_at(code_i, 32'hFE00707F, 32'h00004033)) func = FN_XOR;
    else if (match_at(code_i, 32'hFE00707F, 32'h00005033)) func = FN_SRL;
    else if (match_at(code_i, 32'hFE00707F, 32'h40005033)) func = FN_SRA;
    else if (match_at(code_i, 32'hFE00707F, 32'h00006033)) func = FN_OR;
    else if (match_at(code_i, 32'hFE00707F, 32'h00007033)) func = FN_AND;
    else if (match_at(code_i, 32'h0000707F, 32'h0000001B)) func = FN_ADDIW;
    else if (match_at(code_i, 32'hFE00707F, 32'h0000101B)) func = FN_SLLIW;
    else if (match_at(code_i, 32'hFE00707F, 32'h0000501B)) func = FN_SRLIW;
    else if (match_at(code_i, 32'hFE00707F, 32'h4000501B)) func = FN_SRAIW;
    else if (match_at(code_i, 32'hFE00707F, 32'h0000003B)) func = FN_ADDW;
    else if (match_at(code_i, 32'hFE00707F, 32'h4000003B)) func = FN_SUBW;
    else if (match_at(code_i, 32'hFE00707F, 32'h0000103B)) func = FN_SLLW;
    else if (match_at(code_i, 32'hFE00707F, 32'h0000503B)) func = FN_SRLW;
    else if (match_at(code_i, 32'hFE00707F, 32'h4000503B)) func = FN_SRAW;
    else if (match_at(code_i, 32'hFE00707F, 32'h02000033)) func = FN_MUL;
    else if (match_at(code_i, 32'hFE00707F, 32'h02001033)) func = FN_MULH;
    else if (match_at(code_i, 32'hFE00707F, 32'h02002033)) func = FN_MULHSU;
    else if (match_at(code_i, 32'hFE00707F, 32'h02003033)) func = FN_MULHU;
    else if (match_at(code_i, 32'hFE00707F, 32'h02004033)) func = FN_DIV;
    else if (match_at(code_i, 32'hFE00707F, 32'h02005033)) func = FN_DIVU;
    else if (match_at(code_i, 32'hFE00707F, 32'h02006033)) func = FN_REM;
    else if (match_at(code_i, 32'hFE00707F, 32'h02007033)) func = FN_REMU;
    else if (match_at(code_i, 32'hFE00707F, 32'h0200003B)) func = FN_MULW;
    else if (match_at(code_i, 32'hFE00707F, 32'h0200403B)) func = FN_DIVW;
    else if (match_at(code_i, 32'hFE00707F, 32'h0200503B)) func = FN_DIVUW;
    else if (match_at(code_i, 32'hFE00707F, 32'h0200603B)) func = FN_REMW;
    else if (match_at(code_i, 32'hFE00707F, 32'h0200703B)) func = FN_REMUW;
    else if (match_at(code_i, 32'h0000707F, 32'h00001073)) func = FN_CSRRW;
    else if (match_at(code_i, 32'h0000707F, 32'h00002073)) func = FN_CSRRS;
    else if (match_at(code_i, 32'h0000707F, 32'h00003073)) func = FN_CSRRC;
    else if (match_at(code_i, 32'h0000707F, 32'h00005073)) func = FN_CSRRWI;
    else if (match_at(code_i, 32'h0000707F, 32'h00006073)) func = FN_CSRRSI;
    else if (match_at(code_i, 32'h0000707F, 32'h00007073)) func = FN_CSRRCI;
    else if (match_at(code_i, 32'h0000707F, 32'h0000000F)) func = FN_FENCE;
    else if (match_at(code_i, 32'hFFFFFFFF, 32'h00000073)) func = FN_ECALL;
    else if (match_at(code_i, 32'hFFFFFFFF, 32'h00100073)) func = FN_EBREAK;
    else if (match_at(code_i, 32'hFFFFFFFF, 32'h30200073)) func = FN_MRET;
    else if (match_at(code_i, 32'hFFFFFFFF, 32'h10500073)) func = FN_WFI;
  end

  //////////////////////////////
  // Classification
  //////////////////////////////

  always_comb begin
    is_valid     = (func != FN_INVALID);
    is_branch    = func inside {FN_BEQ, FN_BNE, FN_BLT, FN_BGE, FN_BLTU, FN_BGEU};
    is_load      = func inside {FN_LB, FN_LH, FN_LW, FN_LD, FN_LBU, FN_LHU, FN_LWU};
    is_store     = func inside {FN_SB, FN_SH, FN_SW, FN_SD};
    is_upper     = func inside {FN_LUI, FN_AUIPC};
    is_shift_imm = func inside {FN_SLLI, FN_SRLI, FN_SRAI, FN_SLLIW, FN_SRLIW, FN_SRAIW};
    is_alu_imm   = func inside {FN_ADDI, FN_SLTI, FN_SLTIU, FN_XORI, FN_ORI, FN_ANDI,
                                FN_ADDIW};
    is_alu_reg   = func inside {FN_ADD, FN_SUB, FN_SLL, FN_SLT, FN_SLTU, FN_XOR, FN_SRL,
                                FN_SRA, FN_OR, FN_AND, FN_ADDW, FN_SUBW, FN_SLLW, FN_SRLW,
                                FN_SRAW, FN_MUL, FN_MULH, FN_MULHSU, FN_MULHU, FN_DIV,
                                FN_DIVU, FN_REM, FN_REMU, FN_MULW, FN_DIVW, FN_DIVUW,
                                FN_REMW, FN_REMUW};
    is_csr_reg   = func inside {FN_CSRRW, FN_CSRRS, FN_CSRRC};
    is_csr_imm   = func inside {FN_CSRRWI, FN_CSRRSI, FN_CSRRCI};
    is_sys       = func inside {FN_ECALL, FN_EBREAK, FN_MRET, FN_WFI};
  end

  always_comb begin
    ctrl_o.func = func;

    if (is_shift_imm)    ctrl_o.imm_fmt = IMM_SHAMT;
    else if (is_branch)  ctrl_o.imm_fmt = IMM_B;
    else if (is_csr_imm) ctrl_o.imm_fmt = IMM_CSR;
    else if (is_alu_imm || is_load || is_csr_reg || func == FN_JALR || func == FN_FENCE)
      ctrl_o.imm_fmt = IMM_I;
    else if (func == FN_JAL) ctrl_o.imm_fmt = IMM_J;
    else if (is_store)       ctrl_o.imm_fmt = IMM_S;
    else if (is_upper)       ctrl_o.imm_fmt = IMM_U;
    else                     ctrl_o.imm_fmt = IMM_NONE;

    ctrl_o.reg_use.use_rd  = is_valid & ~(is_branch | is_store | is_sys);
    ctrl_o.reg_use.use_rs1 = is_valid & ~(is_upper | is_csr_imm | is_sys | (func == FN_JAL));
    ctrl_o.reg_use.use_rs2 = is_alu_reg | is_branch | is_store;

    ctrl_o.mem_op   = is_load | is_store;
    ctrl_o.blocking = is_branch | (func inside {FN_JAL, FN_JALR, FN_FENCE, FN_MRET, FN_WFI});
  end

endmodule

`default_nettype wire

// ==== rtl/imm_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
  input  logic [rvdec_pkg::ILEN-1:0] code_i,
  input  rvdec_pkg::imm_fmt_e        fmt_i,
  output logic [rvdec_pkg::XLEN-1:0] imm_o
);

  import rvdec_pkg::*;

  logic sign;  // Instruction bit 31

  assign sign = code_i[31];

  always_comb begin
    case (fmt_i)
      IMM_SHAMT: begin
        imm_o = {{(XLEN-6){1'b0}}, code_i[25:20]};
      end
      IMM_B: begin
        imm_o = {{(XLEN-12){sign}}, code_i[7], code_i[30:25], code_i[11:8], 1'b0};
      end
      IMM_CSR: begin
        // uimm above the CSR address
        imm_o = {{(XLEN-17){1'b0}}, code_i[19:15], code_i[31:20]};
      end
      IMM_I: begin
        imm_o = {{(XLEN-12){sign}}, code_i[31:20]};
      end
      IMM_J: begin
        imm_o = {{(XLEN-20){sign}}, code_i[19:12], code_i[20], code_i[30:21], 1'b0};
      end
      IMM_S: begin
        imm_o = {{(XLEN-12){sign}}, code_i[31:25], code_i[11:7]};
      end
      IMM_U: begin
        imm_o = {{(XLEN-32){sign}}, code_i[31:12], 12'd0};  // Sign extended on RV64
      end
      default: begin
        imm_o = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/reg_operand_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_operand_unit (
  input  logic [rvdec_pkg::ILEN-1:0]       code_i,
  input  rvdec_pkg::reg_use_t              use_i,
  input  logic                             blocking_i,
  output logic [rvdec_pkg::REG_ADDR_W-1:0] rd_o,
  output logic [rvdec_pkg::REG_ADDR_W-1:0] rs1_o,
  output logic [rvdec_pkg::REG_ADDR_W-1:0] rs2_o,
  output logic [rvdec_pkg::NUM_REGS-1:0]   reg_req_o
);

  import rvdec_pkg::*;

  //////////////////////////////
  // Register fields
  //////////////////////////////

  // Unused fields fall back to x0
  always_comb begin
    rd_o  = use_i.use_rd  ? code_i[11:7]  : '0;
    rs1_o = use_i.use_rs1 ? code_i[19:15] : '0;
    rs2_o = use_i.use_rs2 ? code_i[24:20] : '0;
  end

  //////////////////////////////
  // Request mask
  //////////////////////////////

  always_comb begin
    reg_req_o        = {NUM_REGS{blocking_i}};  // Blocking claims every register
    reg_req_o[0]     = 1'b1;                    // x0 always requested
    reg_req_o[rd_o]  = 1'b1;
    reg_req_o[rs1_o] = 1'b1;
    reg_req_o[rs2_o] = 1'b1;
  end

endmodule

`default_nettype wire

// ==== rtl/instr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       valid_i,
  input  logic [rvdec_pkg::ILEN-1:0] code_i,
  input  logic [rvdec_pkg::XLEN-1:0] pc_i,
  output logic                       valid_o,
  output rvdec_pkg::decoded_instr_t  cmd_o
);

  import rvdec_pkg::*;

  instr_ctrl_t           ctrl;
  logic [XLEN-1:0]       imm;
  logic [REG_ADDR_W-1:0] rd;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [NUM_REGS-1:0]   reg_req;
  decoded_instr_t        cmd_d;  // Decode of the current word

  //////////////////////////////
  // Decode units
  //////////////////////////////

  instr_matcher i_instr_matcher (
    .code_i (code_i),
    .ctrl_o (ctrl)
  );

  imm_gen i_imm_gen (
    .code_i (code_i),
    .fmt_i  (ctrl.imm_fmt),
    .imm_o  (imm)
  );

  reg_operand_unit i_reg_operand_unit (
    .code_i     (code_i),
    .use_i      (ctrl.reg_use),
    .blocking_i (ctrl.blocking),
    .rd_o       (rd),
    .rs1_o      (rs1),
    .rs2_o      (rs2),
    .reg_req_o  (reg_req)
  );

  always_comb begin
    cmd_d.func     = ctrl.func;
    cmd_d.rd       = rd;
    cmd_d.rs1      = rs1;
    cmd_d.rs2      = rs2;
    cmd_d.imm      = imm;
    cmd_d.pc       = pc_i;
    cmd_d.mem_op   = ctrl.mem_op;
    cmd_d.blocking = ctrl.blocking;
    cmd_d.reg_req  = reg_req;
  end

  //////////////////////////////
  // Output stage
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o <= 1'b0;
      cmd_o   <= '0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) cmd_o <= cmd_d;  // Hold last decode when idle
    end
  end

endmodule

`default_nettype wire

// ==== verification/instr_decoder_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decoder_chk (
  input logic                      clk_i,
  input logic                      reset_i,
  input logic                      valid_i,
  input logic                      valid_o,
  input rvdec_pkg::decoded_instr_t cmd_o
);

  import rvdec_pkg::*;

  //////////////////////////////
  // Output stage
  //////////////////////////////

  assert property (@(posedge clk_i) reset_i |=> !valid_o)
    else $error("valid_o high after reset");

  assert property (@(posedge clk_i) !reset_i |=> (valid_o == $past(valid_i)))
    else $error("valid_o does not follow valid_i");

  //////////////////////////////
  // Decoded fields
  //////////////////////////////

  assert property (@(posedge clk_i) (valid_o && cmd_o.blocking) |-> (&cmd_o.reg_req))
    else $error("blocking instruction without full request mask");

  assert property (@(posedge clk_i) valid_o |-> cmd_o.reg_req[0])
    else $error("x0 missing from request mask");

  // Nothing derived from an unknown word
  assert property (@(posedge clk_i)
    (valid_o && cmd_o.func == FN_INVALID) |->
      (cmd_o.rd == '0 && cmd_o.rs1 == '0 && cmd_o.rs2 == '0 && cmd_o.imm == '0 &&
       !cmd_o.mem_op && !cmd_o.blocking))
    else $error("invalid word with nonzero fields");

endmodule

`default_nettype wire

// ==== verification/instr_decoder_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decoder_tb;

  import rvdec_pkg::*;

  logic                clk_i;
  logic                reset_i;
  logic                valid_i;
  logic [ILEN-1:0]     code_i;
  logic [XLEN-1:0]     pc_i;
  logic                valid_o;
  decoded_instr_t      cmd_o;

  logic                started;
  logic                exp_valid;
  logic                held_valid;  // A word has been loaded since reset
  logic [ILEN-1:0]     held_code;
  logic [XLEN-1:0]     held_pc;
  int unsigned         cycles;
  logic [6:0]          kept_ops [13];

  instr_decoder i_instr_decoder (.*);

  bind instr_decoder instr_decoder_chk i_instr_decoder_chk (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic instr_func_e step(input instr_func_e base, input logic [2:0] k);
    return instr_func_e'(base + {5'd0, k});
  endfunction

  function automatic instr_func_e expected_func(input logic [ILEN-1:0] c);
    logic [2:0]  f3;
    logic [9:0]  f73;
    instr_func_e fn;
    f3  = c[14:12];
    f73 = {c[31:25], c[14:12]};
    fn  = FN_INVALID;
    case (c[6:0])
      7'h37: fn = FN_LUI;
      7'h17: fn = FN_AUIPC;
      7'h6F: fn = FN_JAL;
      7'h67: if (f3 == 3'd0) fn = FN_JALR;
      7'h63: if (f3 > 3'd3) fn = step(FN_BLT, f3 - 3'd4);
             else if (f3 < 3'd2) fn = step(FN_BEQ, f3);
      7'h03: if (f3 != 3'd7) fn = step(FN_LB, f3);
      7'h23: if (f3 < 3'd4) fn = step(FN_SB, f3);
      7'h13: case (f3)
        3'd0: fn = FN_ADDI;
        3'd2: fn = FN_SLTI;
        3'd3: fn = FN_SLTIU;
        3'd4: fn = FN_XORI;
        3'd6: fn = FN_ORI;
        3'd7: fn = FN_ANDI;
        3'd1: if (c[31:26] == 6'h00) fn = FN_SLLI;
        default: if (c[31:26] == 6'h00) fn = FN_SRLI;
                 else if (c[31:26] == 6'h10) fn = FN_SRAI;
      endcase
      7'h33: if (c[31:25] == 7'h01) fn = step(FN_MUL, f3);
             else case (f73)
        {7'h00, 3'd0}: fn = FN_ADD;
        {7'h20, 3'd0}: fn = FN_SUB;
        {7'h00, 3'd1}: fn = FN_SLL;
        {7'h00, 3'd2}: fn = FN_SLT;
        {7'h00, 3'd3}: fn = FN_SLTU;
        {7'h00, 3'd4}: fn = FN_XOR;
        {7'h00, 3'd5}: fn = FN_SRL;
        {7'h20, 3'd5}: fn = FN_SRA;
        {7'h00, 3'd6}: fn = FN_OR;
        {7'h00, 3'd7}: fn = FN_AND;
        default: fn = FN_INVALID;
      endcase
      7'h1B: if (f3 == 3'd0) fn = FN_ADDIW;
             else if (f73 == {7'h00, 3'd1}) fn = FN_SLLIW;
             else if (f73 == {7'h00, 3'd5}) fn = FN_SRLIW;
             else if (f73 == {7'h20, 3'd5}) fn = FN_SRAIW;
      7'h3B: case (f73)
        {7'h00, 3'd0}: fn = FN_ADDW;
        {7'h20, 3'd0}: fn = FN_SUBW;
        {7'h00, 3'd1}: fn = FN_SLLW;
        {7'h00, 3'd5}: fn = FN_SRLW;
        {7'h20, 3'd5}: fn = FN_SRAW;
        {7'h01, 3'd0}: fn = FN_MULW;
        {7'h01, 3'd4}: fn = FN_DIVW;
        {7'h01, 3'd5}: fn = FN_DIVUW;
        {7'h01, 3'd6}: fn = FN_REMW;
        {7'h01, 3'd7}: fn = FN_REMUW;
        default: fn = FN_INVALID;
      endcase
      7'h73: if (c == 32'h0000_0073) fn = FN_ECALL;
             else if (c == 32'h0010_0073) fn = FN_EBREAK;
             else if (c == 32'h3020_0073) fn = FN_MRET;
             else if (c == 32'h1050_0073) fn = FN_WFI;
             else if (f3 > 3'd4) fn = step(FN_CSRRWI, f3 - 3'd5);
             else if (f3 != 3'd0 && f3 != 3'd4) fn = step(FN_CSRRW, f3 - 3'd1);
      7'h0F: if (f3 == 3'd0) fn = FN_FENCE;
      default: fn = FN_INVALID;
    endcase
    return fn;
  endfunction

  function automatic decoded_instr_t expected_cmd(input logic [ILEN-1:0] c,
                                                  input logic [XLEN-1:0] pc);
    decoded_instr_t d;
    instr_func_e    fn;
    logic           br, ld, st, sys, csri, alur, use_rd, use_rs1, use_rs2;
    fn   = expected_func(c);
    br   = fn inside {[FN_BEQ:FN_BGEU]};
    ld   = fn inside {[FN_LB:FN_LWU]};
    st   = fn inside {[FN_SB:FN_SD]};
    sys  = fn inside {FN_ECALL, FN_EBREAK, FN_MRET, FN_WFI};
    csri = fn inside {FN_CSRRWI, FN_CSRRSI, FN_CSRRCI};
    alur = fn inside {[FN_ADD:FN_AND], [FN_ADDW:FN_SRAW], [FN_MUL:FN_REMUW]};
    use_rd  = fn != FN_INVALID && !(br || st || sys);
    use_rs1 = fn != FN_INVALID && !(sys || csri || fn inside {FN_LUI, FN_AUIPC, FN_JAL});
    use_rs2 = alur || br || st;
    d          = '0;
    d.func     = fn;
    d.pc       = pc;
    d.rd       = use_rd  ? c[11:7]  : 5'd0;
    d.rs1      = use_rs1 ? c[19:15] : 5'd0;
    d.rs2      = use_rs2 ? c[24:20] : 5'd0;
    d.mem_op   = ld || st;
    d.blocking = br || fn inside {FN_JAL, FN_JALR, FN_FENCE, FN_MRET, FN_WFI};
    // Sign extension by arithmetic shift from the top
    if (fn inside {FN_SLLI, FN_SRLI, FN_SRAI, FN_SLLIW, FN_SRLIW, FN_SRAIW})
      d.imm = {58'd0, c[25:20]};
    else if (br)
      d.imm = $signed({c[31], c[7], c[30:25], c[11:8], 1'b0, 51'd0}) >>> 51;
    else if (csri)
      d.imm = {47'd0, c[19:15], c[31:20]};
    else if (fn == FN_JAL)
      d.imm = $signed({c[31], c[19:12], c[20], c[30:21], 1'b0, 43'd0}) >>> 43;
    else if (st)
      d.imm = $signed({c[31:25], c[11:7], 52'd0}) >>> 52;
    else if (fn inside {FN_LUI, FN_AUIPC})
      d.imm = $signed({c[31:12], 44'd0}) >>> 32;
    else if (fn != FN_INVALID && !alur && !sys)
      d.imm = $signed({c[31:20], 52'd0}) >>> 52;  // I format
    if (d.blocking)
      d.reg_req = '1;
    else
      d.reg_req = 32'd1 | (32'd1 << d.rd) | (32'd1 << d.rs1) | (32'd1 << d.rs2);
    return d;
  endfunction

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic check_field(input string name, input logic [63:0] expv,
                             input logic [63:0] actv);
    assert (expv === actv) else begin
      $display("ERR %s expected 0x%0h actual 0x%0h", name, expv, actv);
      $display("CHECKS FAILED");
      $fatal(1, "decode mismatch");
    end
  endtask

  always @(posedge clk_i) begin
    started   <= 1'b1;
    cycles    <= cycles + 1;
    exp_valid <= reset_i ? 1'b0 : valid_i;
    if (reset_i) begin
      held_valid <= 1'b0;
    end else if (valid_i) begin
      held_valid <= 1'b1;
      held_code  <= code_i;
      held_pc    <= pc_i;
    end
    if (cycles >= 5000) begin  // About 2,400 cycles of stimulus
      $display("Timeout: the run did not finish within the cycle limit");
      $display("CHECKS FAILED");
      $fatal(1, "timeout");
    end
  end

  always @(negedge clk_i) begin
    decoded_instr_t exp;
    if (started) begin
      exp = held_valid ? expected_cmd(held_code, held_pc) : '0;  // Zero after reset
      check_field("valid_o", {63'd0, exp_valid}, {63'd0, valid_o});
      check_field("func", {56'd0, exp.func}, {56'd0, cmd_o.func});
      check_field("rd", {59'd0, exp.rd}, {59'd0, cmd_o.rd});
      check_field("rs1", {59'd0, exp.rs1}, {59'd0, cmd_o.rs1});
      check_field("rs2", {59'd0, exp.rs2}, {59'd0, cmd_o.rs2});
      check_field("imm", exp.imm, cmd_o.imm);
      check_field("pc", exp.pc, cmd_o.pc);
      check_field("mem_op", {63'd0, exp.mem_op}, {63'd0, cmd_o.mem_op});
      check_field("blocking", {63'd0, exp.blocking}, {63'd0, cmd_o.blocking});
      check_field("reg_req", {32'd0, exp.reg_req}, {32'd0, cmd_o.reg_req});
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic drive(input logic v, input logic [ILEN-1:0] c, input logic [XLEN-1:0] pc);
    @(posedge clk_i);
    valid_i <= v;
    code_i  <= c;
    pc_i    <= pc;
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] w;
    logic [6:0]  funct7s [3];
    reset_i    = 1'b1;
    valid_i    = 1'b0;
    code_i     = '0;
    pc_i       = '0;
    started    = 1'b0;
    exp_valid  = 1'b0;
    held_valid = 1'b0;
    held_code  = '0;
    held_pc    = '0;
    cycles     = 0;
    kept_ops   = '{7'h37, 7'h17, 7'h6F, 7'h67, 7'h63, 7'h03, 7'h23,
                   7'h13, 7'h33, 7'h1B, 7'h3B, 7'h73, 7'h0F};
    funct7s    = '{7'h00, 7'h20, 7'h01};
    void'($urandom(32'he301_6357));
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;

    // Every opcode with each funct3 and funct7 variant
    foreach (kept_ops[i]) begin
      for (int f3 = 0; f3 < 8; f3++) begin
        foreach (funct7s[k]) begin
          r = $urandom;
          w = {funct7s[k], r[24:15], 3'(f3), r[11:7], kept_ops[i]};
          drive(1'b1, w, 64'h8000_0000 + 64'(cycles) * 4);
        end
      end
    end
    drive(1'b1, 32'h0000_0073, 64'h100);
    drive(1'b1, 32'h0010_0073, 64'h104);
    drive(1'b1, 32'h3020_0073, 64'h108);
    drive(1'b1, 32'h1050_0073, 64'h10C);
    drive(1'b1, 32'h00C5_A52F, 64'h110);  // AMOADD_W
    drive(1'b1, 32'h00C5_8553, 64'h114);  // FADD_S
    drive(1'b0, 32'hFFFF_FFFF, 64'h118);

    for (int n = 0; n < 2000; n++) begin
      r = $urandom;
      w = $urandom;
      if (r[0]) w[6:0] = kept_ops[r[7:4] % 13];
      drive(r[1] | r[2], w, {$urandom, $urandom});
    end
    drive(1'b0, '0, '0);
    repeat (3) @(posedge clk_i);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rvdec.f ====
rtl/rvdec_pkg.sv
rtl/instr_matcher.sv
rtl/imm_gen.sv
rtl/reg_operand_unit.sv
rtl/instr_decoder.sv
verification/instr_decoder_chk.sv
verification/instr_decoder_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the rvdec testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  -f rvdec.f \
  --top-module instr_decoder_tb \
  -Mdir obj_dir -o instr_decoder_sim
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/instr_decoder_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "ALL CHECKS PASSED" "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
